/* Makefile */
VERILATOR  ?= verilator
FILELIST   := rx_dma_top.f
RTL_TOP    := rx_dma_top
TB_TOP     := tb_rx_dma
LINT_FLAGS := --lint-only --timing
SIM_FLAGS  := --binary --timing
BUILD_DIR  := obj_dir
LOG        := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TB_TOP) \
		--Mdir $(BUILD_DIR) -o V$(TB_TOP)
	./$(BUILD_DIR)/V$(TB_TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then exit 1; fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_rx_dma.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dma_config.svh"

module tb_rx_dma;

  import rx_dma_pkg::*;

  localparam int CLK_PERIOD   = 8;
  // Outputs are read this long after the falling edge, just before the rising one
  localparam int SAMPLE_DLY   = 3;
  localparam int RESET_CYCLES = 3;
  localparam int BYTES        = `RX_WORD_BYTES;
  localparam int ADDR_W       = `RX_ADDR_W;
  localparam int LEN_W        = `RX_LEN_W;
  localparam int SLOT_W       = `RX_SLOT_W;
  localparam int PORT_W       = `RX_PORT_W;
  localparam int SLOT_BYTES   = 1 << `RX_SLOT_LOW_BITS;
  localparam int OFFSET       = `RX_SLOT_OFFSET;
  localparam logic [31:0] LFSR_SEED = 32'h54af_4a47;

  // Run budget, at most three packets of five beats per test, each write
  // slowed by random back-pressure, plus the descriptor waits
  localparam int TEST_COUNT   = 5;
  localparam int MAX_PKTS     = 3;
  localparam int MAX_BEATS    = 5;
  localparam int STALL_FACTOR = 4;
  localparam int DESC_WAIT    = 64;
  localparam int HOLD_CYCLES  = 6;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + TEST_COUNT *
    (MAX_PKTS * (MAX_BEATS + 2) * STALL_FACTOR + 2 * DESC_WAIT + HOLD_CYCLES);

  logic              clk;
  logic              rst;
  axis_beat_t        s_axis;
  logic              s_axis_tvalid;
  logic              s_axis_tready;
  logic [SLOT_W-1:0] s_axis_tdest;
  logic [PORT_W-1:0] s_axis_tuser;
  mem_wr_t           mem_wr;
  logic              mem_wr_en;
  logic              mem_wr_ready;
  recv_desc_t        recv_desc;
  logic              recv_desc_valid;
  logic              recv_desc_ready;

  // Memory model and the image it should end up matching
  logic [7:0]  mem     [0:(1<<ADDR_W)-1];
  logic [7:0]  exp_mem [0:(1<<ADDR_W)-1];
  recv_desc_t  got_q[$];
  recv_desc_t  exp_q[$];
  int          used_slots[$];
  // Word address of the final write of each packet still in flight
  logic [ADDR_W-1:0] last_word_q[$];
  logic [31:0] lfsr_state;
  logic        rand_ready;
  int          pkt_id;
  int          error_count;
  int          tests_failed;

  rx_dma_top dut_i (
    .clk             (clk),
    .rst             (rst),
    .s_axis          (s_axis),
    .s_axis_tvalid   (s_axis_tvalid),
    .s_axis_tready   (s_axis_tready),
    .s_axis_tdest    (s_axis_tdest),
    .s_axis_tuser    (s_axis_tuser),
    .mem_wr          (mem_wr),
    .mem_wr_en       (mem_wr_en),
    .mem_wr_ready    (mem_wr_ready),
    .recv_desc       (recv_desc),
    .recv_desc_valid (recv_desc_valid),
    .recv_desc_ready (recv_desc_ready)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  //////////////////////////////
  // Helpers
  //////////////////////////////

  // Fibonacci LFSR with taps 32, 22, 2 and 1, one step per bit
  function automatic logic lfsr_step();
    logic fb;
    fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
    lfsr_state = {lfsr_state[30:0], fb};
    return fb;
  endfunction

  // Background contents, every address bit changes the byte
  function automatic logic [7:0] fill_byte(input logic [ADDR_W-1:0] a);
    return a[7:0] ^ {a[14:8], a[15]} ^ 8'h5a;
  endfunction

  // Payload byte k of packet id, different for every packet
  function automatic logic [7:0] pkt_byte(input int id, input int k);
    return 8'(k * 7 + id * 61 + 3);
  endfunction

  task automatic check_val(input string name, input logic [63:0] got,
                           input logic [63:0] exp);
    if (got !== exp) begin
      $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, exp);
      error_count++;
    end
  endtask

  task automatic end_test(input string name, input int errs0);
    if (error_count == errs0) begin
      $display("test %s: ok", name);
    end else begin
      $display("test %s: failed with %0d errors", name, error_count - errs0);
      tests_failed++;
    end
  endtask

  // Memory writes and taken descriptors are both recorded at the sample point
  // The write covering a packet's final byte must carry the last flag
  always begin
    logic [ADDR_W-1:0] a;
    logic              last_exp;
    @(negedge clk);
    #SAMPLE_DLY;
    if (mem_wr_en && mem_wr_ready) begin
      last_exp = (last_word_q.size() > 0) && (mem_wr.addr == last_word_q[0]);
      check_val("mem_wr.last", 64'(mem_wr.last), 64'(last_exp));
      if (last_exp) begin
        last_word_q.delete(0);
      end
      for (int i = 0; i < BYTES; i++) begin
        a = mem_wr.addr + ADDR_W'(i);
        if (mem_wr.strb[i]) begin
          mem[a] = mem_wr.data[8*i +: 8];
        end
      end
    end
    if (recv_desc_valid && recv_desc_ready) begin
      got_q.push_back(recv_desc);
    end
  end

  // Memory accepts every write unless random back-pressure is switched on
  initial begin
    mem_wr_ready = 1'b1;
    forever begin
      @(negedge clk);
      mem_wr_ready = rand_ready ? lfsr_step() : 1'b1;
    end
  end

  // Watchdog
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("watchdog expired after %0d cycles, the DUT stopped responding",
             WATCHDOG_CYCLES);
    $display("Simulation FAILED");
    $finish;
  end

  //////////////////////////////
  // Stimulus and checks
  //////////////////////////////

  // Starts and ends on a falling edge, so consecutive calls run back to back
  // A nonzero hold checks that the last beat waits on the pending descriptor
  task automatic send_packet(input int slot, input int port, input int nbytes,
                             input int hold);
    axis_beat_t        b;
    recv_desc_t        d;
    logic [ADDR_W-1:0] a;
    int                nbeats;
    int                k;
    logic              taken;
    nbeats = (nbytes + BYTES - 1) / BYTES;
    // Packet byte k belongs at slot start plus offset plus k
    for (int i = 0; i < nbytes; i++) begin
      a = ADDR_W'(slot * SLOT_BYTES + OFFSET + i);
      exp_mem[a] = pkt_byte(pkt_id, i);
    end
    // The final write is the word holding the packet's final byte
    a = ADDR_W'(((slot * SLOT_BYTES + OFFSET + nbytes - 1) / BYTES) * BYTES);
    last_word_q.push_back(a);
    for (int bi = 0; bi < nbeats; bi++) begin
      for (int j = 0; j < BYTES; j++) begin
        k = bi * BYTES + j;
        b.data[8*j +: 8] = (k < nbytes) ? pkt_byte(pkt_id, k) : 8'hee;
        b.keep[j] = (k < nbytes);
      end
      b.last = (bi == nbeats - 1);
      s_axis = b;
      s_axis_tvalid = 1'b1;
      s_axis_tdest = SLOT_W'(slot);
      s_axis_tuser = PORT_W'(port);
      if (b.last && hold > 0) begin
        repeat (hold) begin
          #SAMPLE_DLY;
          check_val("s_axis_tready", 64'(s_axis_tready), 64'(0));
          @(negedge clk);
        end
        recv_desc_ready = 1'b1;
      end
      taken = 1'b0;
      while (!taken) begin
        #SAMPLE_DLY;
        taken = s_axis_tready;
        @(negedge clk);
      end
    end
    s_axis_tvalid = 1'b0;
    d.addr = ADDR_W'(slot * SLOT_BYTES + OFFSET);
    d.len  = LEN_W'(nbytes);
    d.slot = SLOT_W'(slot);
    d.port = PORT_W'(port);
    exp_q.push_back(d);
    used_slots.push_back(slot);
    pkt_id++;
  endtask

  task automatic wait_desc_valid();
    logic seen;
    seen = 1'b0;
    for (int i = 0; i < DESC_WAIT && !seen; i++) begin
      #SAMPLE_DLY;
      seen = recv_desc_valid;
      @(negedge clk);
    end
    if (!seen) begin
      $display("descriptor valid never rose within %0d cycles", DESC_WAIT);
      error_count++;
    end
  endtask

  // Waits for all expected descriptors, then compares them in order
  task automatic check_descs();
    recv_desc_t g;
    recv_desc_t e;
    int         n;
    n = 0;
    while (got_q.size() < exp_q.size() && n < DESC_WAIT) begin
      @(negedge clk);
      n++;
    end
    // A few more cycles let a stray descriptor show up
    repeat (4) @(negedge clk);
    if (got_q.size() != exp_q.size()) begin
      $display("wrong number of descriptors at %0d ns: got %0d, expected %0d",
               $time, got_q.size(), exp_q.size());
      error_count++;
    end
    if (last_word_q.size() != 0) begin
      $display("%0d packets ended without a write marked last at %0d ns",
               last_word_q.size(), $time);
      error_count++;
      last_word_q.delete();
    end
    while (got_q.size() > 0 && exp_q.size() > 0) begin
      g = got_q.pop_front();
      e = exp_q.pop_front();
      check_val("recv_desc.addr", 64'(g.addr), 64'(e.addr));
      check_val("recv_desc.len", 64'(g.len), 64'(e.len));
      check_val("recv_desc.slot", 64'(g.slot), 64'(e.slot));
      check_val("recv_desc.port", 64'(g.port), 64'(e.port));
    end
    got_q.delete();
    exp_q.delete();
  endtask

  // Whole slots are compared so stray or missing bytes both show
  task automatic check_slots();
    logic [ADDR_W-1:0] a;
    int                base;
    while (used_slots.size() > 0) begin
      base = used_slots.pop_front();
      for (int i = 0; i < SLOT_BYTES; i++) begin
        a = ADDR_W'(base * SLOT_BYTES + i);
        check_val($sformatf("mem[%04h]", a), 64'(mem[a]), 64'(exp_mem[a]));
      end
    end
  endtask

  task automatic test_single_beat();
    int errs0;
    errs0 = error_count;
    send_packet('h10, 1, 8, 0);
    check_descs();
    check_slots();
    end_test("single full beat", errs0);
  endtask

  // Seven bytes in the last beat spill past the word and need the extra write
  task automatic test_extra_write();
    int errs0;
    errs0 = error_count;
    send_packet('h11, 2, 23, 0);
    check_descs();
    check_slots();
    end_test("extra last write", errs0);
  endtask

  task automatic test_backpressure();
    int errs0;
    errs0 = error_count;
    @(posedge clk);
    rand_ready = 1'b1;
    @(negedge clk);
    send_packet('h12, 3, 40, 0);
    check_descs();
    @(posedge clk);
    rand_ready = 1'b0;
    @(negedge clk);
    check_slots();
    end_test("memory back-pressure", errs0);
  endtask

  task automatic test_desc_hold();
    int errs0;
    errs0 = error_count;
    recv_desc_ready = 1'b0;
    send_packet('h21, 1, 16, 0);
    wait_desc_valid();
    send_packet('h22, 2, 12, HOLD_CYCLES);
    check_descs();
    check_slots();
    end_test("descriptor hold", errs0);
  endtask

  task automatic test_back_to_back();
    int errs0;
    errs0 = error_count;
    send_packet('h40, 0, 13, 0);
    send_packet('h41, 3, 22, 0);
    send_packet('h42, 2, 31, 0);
    check_descs();
    check_slots();
    end_test("back to back", errs0);
  endtask

  initial begin
    rst = 1'b1;
    s_axis = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tdest = '0;
    s_axis_tuser = '0;
    recv_desc_ready = 1'b1;
    rand_ready = 1'b0;
    lfsr_state = LFSR_SEED;
    pkt_id = 0;
    error_count = 0;
    tests_failed = 0;
    for (int a = 0; a < (1 << ADDR_W); a++) begin
      mem[a] = fill_byte(ADDR_W'(a));
      exp_mem[a] = fill_byte(ADDR_W'(a));
    end
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    test_single_beat();
    test_extra_write();
    test_backpressure();
    test_desc_hold();
    test_back_to_back();
    $display("tests %0d, failed %0d, errors %0d", TEST_COUNT, tests_failed, error_count);
    if (error_count == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* common/rx_dma_config.svh */
`ifndef RX_DMA_CONFIG_SVH
`define RX_DMA_CONFIG_SVH

// Bytes in one stream beat and in one memory word
`define RX_WORD_BYTES    8
`define RX_DATA_W        (`RX_WORD_BYTES * 8)
// Byte lane index bits inside one word
`define RX_MASK_BITS     $clog2(`RX_WORD_BYTES)

// Memory byte address and packet length widths
`define RX_ADDR_W        16
`define RX_LEN_W         16

// Each slot covers 2^RX_SLOT_LOW_BITS bytes, tdest picks the slot
`define RX_SLOT_LOW_BITS 8
`define RX_SLOT_W        (`RX_ADDR_W - `RX_SLOT_LOW_BITS)
// First packet byte sits this far into the slot, must stay below one word
`define RX_SLOT_OFFSET   2

// Ingress port number carried on tuser
`define RX_PORT_W        2

`endif

/* common/rx_dma_pkg.sv */
`default_nettype none

`include "rx_dma_config.svh"

package rx_dma_pkg;

  // One beat of the incoming stream, tdest and tuser travel beside it
  typedef struct packed {
    logic [`RX_DATA_W-1:0]     data;
    logic [`RX_WORD_BYTES-1:0] keep;
    logic                      last;
  } axis_beat_t;

  // Per-packet metadata latched from the first beat
  typedef struct packed {
    logic [`RX_SLOT_W-1:0] slot;
    logic [`RX_PORT_W-1:0] port;
  } rx_meta_t;

  // One word write towards packet memory
  typedef struct packed {
    logic [`RX_ADDR_W-1:0]     addr;
    logic [`RX_DATA_W-1:0]     data;
    logic [`RX_WORD_BYTES-1:0] strb;
    logic                      last;
  } mem_wr_t;

  // Receive descriptor handed out once a packet sits in memory
  // The address is the byte address of the first packet byte
  typedef struct packed {
    logic [`RX_ADDR_W-1:0] addr;
    logic [`RX_LEN_W-1:0]  len;
    logic [`RX_SLOT_W-1:0] slot;
    logic [`RX_PORT_W-1:0] port;
  } recv_desc_t;

endpackage

`default_nettype wire

/* hw/rx_desc_gen.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dma_config.svh"

module rx_desc_gen (
  input  wire                        clk,
  input  wire                        rst,

  // Packet metadata and write events
  input  wire rx_dma_pkg::rx_meta_t  meta,
  input  wire                        wr_fire,
  input  wire [`RX_WORD_BYTES-1:0]   wr_strb,
  input  wire                        wr_first,
  input  wire                        wr_done,

  // Descriptor port
  output rx_dma_pkg::recv_desc_t     desc,
  output logic                       desc_valid,
  input  wire                        desc_ready,

  // Held descriptor, blocks the last beat of the next packet
  output logic                       desc_busy
);

  localparam int BYTES    = `RX_WORD_BYTES;
  localparam int CNT_W    = `RX_MASK_BITS + 1;
  localparam int LEN_W    = `RX_LEN_W;
  localparam int LOW_BITS = `RX_SLOT_LOW_BITS;

  logic [CNT_W-1:0] strb_cnt;
  logic [LEN_W-1:0] len_acc;
  logic [LEN_W-1:0] len_next;

  ////////////////////////////////
  // Byte count
  ////////////////////////////////

  // Set strobe bits of the current write, zero strobes are allowed
  always_comb begin
    strb_cnt = '0;
    for (int i = 0; i < BYTES; i++) begin
      strb_cnt = strb_cnt + CNT_W'(wr_strb[i]);
    end
  end

  // First write of a packet restarts the running total
  assign len_next = wr_first ? LEN_W'(strb_cnt) : len_acc + LEN_W'(strb_cnt);

  always_ff @(posedge clk) begin
    if (wr_fire) begin
      len_acc <= len_next;
    end
  end

  ////////////////////////////////
  // Descriptor register
  ////////////////////////////////

  // The input side never lets a packet finish while a descriptor waits,
  // so loading here cannot overwrite an untaken entry
  always_ff @(posedge clk) begin
    if (wr_fire && wr_done) begin
      desc.addr <= {meta.slot, LOW_BITS'(`RX_SLOT_OFFSET)};
      desc.len  <= len_next;
      desc.slot <= meta.slot;
      desc.port <= meta.port;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      desc_valid <= 1'b0;
    end else if (wr_fire && wr_done) begin
      desc_valid <= 1'b1;
    end else if (desc_ready) begin
      desc_valid <= 1'b0;
    end
  end

  // Taken this cycle counts as free
  // A descriptor loading on this edge already counts as busy
  // That keeps a one-beat packet from slipping in behind the final write
  assign desc_busy = (desc_valid && !desc_ready) || (wr_fire && wr_done);

endmodule

`default_nettype wire

/* hw/rx_dma_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dma_config.svh"

module rx_dma_top (
  input  wire                             clk,
  input  wire                             rst,

  // Stream input, tdest is the slot number and tuser the ingress port
  input  wire rx_dma_pkg::axis_beat_t     s_axis,
  input  wire                             s_axis_tvalid,
  output logic                            s_axis_tready,
  input  wire [`RX_SLOT_W-1:0]            s_axis_tdest,
  input  wire [`RX_PORT_W-1:0]            s_axis_tuser,

  // Memory write port
  output rx_dma_pkg::mem_wr_t             mem_wr,
  output logic                            mem_wr_en,
  input  wire                             mem_wr_ready,

  // Receive descriptor port
  output rx_dma_pkg::recv_desc_t          recv_desc,
  output logic                            recv_desc_valid,
  input  wire                             recv_desc_ready
);

  import rx_dma_pkg::*;

  ////////////////////////////////
  // Internal wiring
  ////////////////////////////////

  axis_beat_t beat;
  rx_meta_t   meta;
  logic       beat_take;
  logic       first_beat;
  logic       wr_stall;
  logic       desc_busy;
  logic       wr_fire;
  logic       wr_first;
  logic       wr_done;

  // Input side, owns tready and the packet metadata
  rx_slot_capture cap_i (
    .clk        (clk),
    .rst        (rst),
    .s_beat     (s_axis),
    .s_valid    (s_axis_tvalid),
    .s_dest     (s_axis_tdest),
    .s_user     (s_axis_tuser),
    .s_ready    (s_axis_tready),
    .wr_stall   (wr_stall),
    .desc_busy  (desc_busy),
    .beat       (beat),
    .beat_take  (beat_take),
    .first_beat (first_beat),
    .meta       (meta)
  );

  // Realignment pipeline, drives the memory write port directly
  rx_realign align_i (
    .clk          (clk),
    .rst          (rst),
    .beat         (beat),
    .beat_take    (beat_take),
    .first_beat   (first_beat),
    .slot         (meta.slot),
    .wr_stall     (wr_stall),
    .mem_wr       (mem_wr),
    .mem_wr_en    (mem_wr_en),
    .mem_wr_ready (mem_wr_ready),
    .wr_fire      (wr_fire),
    .wr_first     (wr_first),
    .wr_done      (wr_done)
  );

  // Output side, length count and descriptor register
  rx_desc_gen desc_i (
    .clk        (clk),
    .rst        (rst),
    .meta       (meta),
    .wr_fire    (wr_fire),
    .wr_strb    (mem_wr.strb),
    .wr_first   (wr_first),
    .wr_done    (wr_done),
    .desc       (recv_desc),
    .desc_valid (recv_desc_valid),
    .desc_ready (recv_desc_ready),
    .desc_busy  (desc_busy)
  );

endmodule

`default_nettype wire

/* hw/rx_realign.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dma_config.svh"

module rx_realign (
  input  wire                         clk,
  input  wire                         rst,

  // Accepted beats from the input side
  input  wire rx_dma_pkg::axis_beat_t beat,
  input  wire                         beat_take,
  input  wire                         first_beat,
  input  wire [`RX_SLOT_W-1:0]        slot,
  output logic                        wr_stall,

  // Memory write port
  output rx_dma_pkg::mem_wr_t         mem_wr,
  output logic                        mem_wr_en,
  input  wire                         mem_wr_ready,

  // Write events for the descriptor side
  output logic                        wr_fire,
  output logic                        wr_first,
  output logic                        wr_done
);

  localparam int DATA_W   = `RX_DATA_W;
  localparam int BYTES    = `RX_WORD_BYTES;
  localparam int ADDR_W   = `RX_ADDR_W;
  localparam int LOW_BITS = `RX_SLOT_LOW_BITS;
  // Bytes of a beat that still fit in the word it starts in
  localparam int WRAP_OFF = `RX_WORD_BYTES - `RX_SLOT_OFFSET;

  // Stage 1 holds the newest beat, stage 2 the one before it
  logic [DATA_W-1:0]   stg1_data;
  logic [DATA_W-1:0]   stg2_data;
  logic [BYTES-1:0]    stg1_strb;
  logic [BYTES-1:0]    stg2_strb;
  logic                stg1_last;
  logic                extra_r;
  logic                strb_left;
  logic                extra_cycle;
  logic [ADDR_W-1:0]   slot_base;
  logic [ADDR_W-1:0]   next_addr;
  logic [ADDR_W-1:0]   wr_addr;
  logic [2*DATA_W-1:0] data_pair;
  logic [2*BYTES-1:0]  strb_pair;

  ////////////////////////////////
  // Write control
  ////////////////////////////////

  // A last beat with bytes above the wrap point spills into one more word
  assign strb_left   = |(stg1_strb >> WRAP_OFF);
  assign extra_cycle = mem_wr_en && stg1_last && strb_left;

  assign wr_fire  = mem_wr_en && mem_wr_ready;
  assign wr_stall = (mem_wr_en && !mem_wr_ready) || extra_cycle;
  // Final write is either the last beat itself or the extra spill word
  assign wr_done  = mem_wr_en && ((stg1_last && !extra_cycle) || extra_r);

  // The offset is below one word, so the first word starts at the slot base
  assign slot_base = {slot, {LOW_BITS{1'b0}}};
  assign wr_addr   = wr_first ? slot_base : next_addr;

  // Low bytes come from the tail of the older beat, the rest from the newer
  assign data_pair = {stg1_data, stg2_data} >> (WRAP_OFF * 8);
  assign strb_pair = {stg1_strb, stg2_strb} >> WRAP_OFF;

  always_comb begin
    mem_wr.addr = wr_addr;
    mem_wr.data = data_pair[DATA_W-1:0];
    mem_wr.strb = strb_pair[BYTES-1:0];
    mem_wr.last = wr_done;
  end

  // Enable rises after a taken beat, stays up through back-pressure,
  // and stays up once more when the spill word follows
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wr_en <= 1'b0;
      extra_r   <= 1'b0;
      wr_first  <= 1'b0;
    end else begin
      mem_wr_en <= beat_take || (wr_fire && extra_cycle) || (mem_wr_en && !mem_wr_ready);
      if (wr_fire) begin
        extra_r <= extra_cycle;
      end
      wr_first <= (beat_take && first_beat) || (wr_first && !wr_fire);
    end
  end

  // Address steps one word per accepted write
  always_ff @(posedge clk) begin
    if (wr_fire) begin
      next_addr <= wr_addr + ADDR_W'(BYTES);
    end
  end

  ////////////////////////////////
  // Data stages
  ////////////////////////////////

  // Stage 1 is emptied when its spill has moved down or the packet is done
  always_ff @(posedge clk) begin
    if (rst) begin
      stg1_strb <= '0;
      stg1_last <= 1'b0;
    end else if (beat_take) begin
      stg1_strb <= beat.keep;
      stg1_last <= beat.last;
    end else if (wr_fire && (extra_cycle || wr_done)) begin
      stg1_strb <= '0;
      stg1_last <= 1'b0;
    end
  end

  // Stage 2 starts every packet empty
  always_ff @(posedge clk) begin
    if (rst) begin
      stg2_strb <= '0;
    end else if (wr_fire) begin
      if (wr_done) begin
        stg2_strb <= '0;
      end else begin
        stg2_strb <= stg1_strb;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (beat_take) begin
      stg1_data <= beat.data;
    end
    if (wr_fire) begin
      stg2_data <= stg1_data;
    end
  end

endmodule

`default_nettype wire

/* hw/rx_slot_capture.sv */
`timescale 1ns/1ps
`default_nettype none

`include "rx_dma_config.svh"

module rx_slot_capture (
  input  wire                         clk,
  input  wire                         rst,

  // Stream side
  input  wire rx_dma_pkg::axis_beat_t s_beat,
  input  wire                         s_valid,
  input  wire [`RX_SLOT_W-1:0]        s_dest,
  input  wire [`RX_PORT_W-1:0]        s_user,
  output logic                        s_ready,

  // Hold-off from the write pipeline and the descriptor register
  input  wire                         wr_stall,
  input  wire                         desc_busy,

  // Accepted beat towards the realignment pipeline
  output rx_dma_pkg::axis_beat_t      beat,
  output logic                        beat_take,
  output logic                        first_beat,

  // Metadata of the packet now being written
  output rx_dma_pkg::rx_meta_t        meta
);

  // Idle means the next accepted beat opens a new packet
  typedef enum logic {
    ST_IDLE,
    ST_PKT
  } cap_state_e;

  cap_state_e state;

  ////////////////////////////////
  // Handshake
  ////////////////////////////////

  // The pipeline stalls on memory back-pressure or while it inserts
  // the extra write of a last beat
  // A last beat is also held back while the previous descriptor waits,
  // so the descriptor register is free by the time this packet ends
  assign s_ready   = !wr_stall && !(s_beat.last && desc_busy);
  assign beat_take = s_valid && s_ready;

  // The beat goes on unchanged, the pipeline only loads it on beat_take
  assign beat = s_beat;

  // First beat of a packet is any beat taken while idle
  assign first_beat = (state == ST_IDLE);

  ////////////////////////////////
  // Packet state
  ////////////////////////////////

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= ST_IDLE;
    end else if (beat_take) begin
      // A one-beat packet never leaves idle
      if (s_beat.last) begin
        state <= ST_IDLE;
      end else begin
        state <= ST_PKT;
      end
    end
  end

  // Slot and port are sampled once per packet, on its first beat
  // tdest and tuser on later beats are ignored
  always_ff @(posedge clk) begin
    if (beat_take && first_beat) begin
      meta.slot <= s_dest;
      meta.port <= s_user;
    end
  end

endmodule

`default_nettype wire

/* rx_dma_top.f */
+incdir+common
common/rx_dma_pkg.sv
hw/rx_slot_capture.sv
hw/rx_realign.sv
hw/rx_desc_gen.sv
hw/rx_dma_top.sv
bench/tb_rx_dma.sv
